/* Bender.yml */
package:
  name: ex_unit

sources:
  - files:
      - logic/ex_pkg.sv
      - logic/ex_issue_buffer.sv
      - logic/ex_alu.sv
      - logic/ex_divider.sv
      - logic/ex_stage.sv
      - logic/ex_result_buffer.sv
      - logic/ex_unit_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/ex_unit_tb.sv

/* bench/ex_ref_model.svh */
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// Expected ALU result from the operation rules
function automatic data_t alu_expect(ex_op_e op, data_t a, data_t b);
    logic [63:0] product;
    int unsigned sh;
    // Shift amount wraps at 32
    sh = b % 32;
    product = 64'(a) * 64'(b);
    case (op)
        OP_ADD:  return a + b;
        OP_SUB:  return a - b;
        OP_AND:  return a & b;
        OP_OR:   return a | b;
        OP_XOR:  return a ^ b;
        OP_SLL:  return a << sh;
        OP_SRL:  return a >> sh;
        // Logical shift with the vacated high bits filled from the sign
        OP_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
        // Differing signs decide by the sign of a
        OP_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : ((a < b) ? 32'd1 : 32'd0);
        OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
        OP_MUL:  return product[31:0];
        default: return '0;
    endcase
endfunction

// Quotient or remainder including divide by zero and overflow
function automatic data_t div_expect(ex_op_e op, data_t a, data_t b);
    logic  want_rem;
    logic  is_signed;
    data_t q;
    data_t r;
    want_rem  = (op == OP_MOD) || (op == OP_MODU);
    is_signed = (op == OP_DIV) || (op == OP_MOD);
    if (b == '0) begin
        q = '1;
        r = a;
    end else if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        q = a;
        r = '0;
    end else if (is_signed) begin
        // Quotient truncates toward zero and the remainder follows a
        q = data_t'($signed(a) / $signed(b));
        r = data_t'($signed(a) % $signed(b));
    end else begin
        q = a / b;
        r = a % b;
    end
    return want_rem ? r : q;
endfunction

function automatic data_t expected_result(ex_op_e op, data_t a, data_t b);
    if (op == OP_DIV || op == OP_DIVU || op == OP_MOD || op == OP_MODU) begin
        return div_expect(op, a, b);
    end
    return alu_expect(op, a, b);
endfunction

`endif

/* bench/ex_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_unit_tb
    import ex_pkg::*;
;

    localparam int IQ_DEPTH    = 4;
    localparam int RB_DEPTH    = 4;
    localparam int OUT_CREDITS = 2;
    localparam int N_ALU       = 14;
    localparam int N_DIV       = 14;
    localparam int N_RAND      = 24;
    localparam int TIMEOUT     = 5000;
    localparam int SEED        = 32'h32cd;

    logic   clk;
    logic   rst;
    logic   in_valid_i;
    ex_op_e in_op_i;
    data_t  in_a_i;
    data_t  in_b_i;
    tag_t   in_tag_i;
    logic   in_credit_o;
    logic   out_valid_o;
    data_t  out_data_o;
    tag_t   out_tag_o;
    logic   out_credit_i;

    // Stimulus table
    ex_op_e tbl_op[$];
    data_t  tbl_a[$];
    data_t  tbl_b[$];
    data_t  tbl_exp[$];

    // Credit and result bookkeeping
    int   up_sent      = 0;
    int   up_returned  = 0;
    int   dn_received  = 0;
    int   dn_returned  = 0;
    int   exp_idx      = 0;
    int   cyc          = 0;
    logic hold_mode    = 1'b0;
    logic timed_out    = 1'b0;
    int   errors       = 0;
    int   n_checks     = 0;
    int   tests_run    = 0;
    int   tests_failed = 0;

    `include "ex_ref_model.svh"

    ex_unit_top #(
        .IQ_DEPTH    (IQ_DEPTH),
        .RB_DEPTH    (RB_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) ex_unit_top_inst (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (in_valid_i),
        .in_op_i      (in_op_i),
        .in_a_i       (in_a_i),
        .in_b_i       (in_b_i),
        .in_tag_i     (in_tag_i),
        .in_credit_o  (in_credit_o),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_tag_o    (out_tag_o),
        .out_credit_i (out_credit_i)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic add_entry(input ex_op_e op, input data_t a, input data_t b,
                             input data_t exp);
        tbl_op.push_back(op);
        tbl_a.push_back(a);
        tbl_b.push_back(b);
        tbl_exp.push_back(exp);
    endtask

    task automatic build_table();
        ex_op_e op;
        data_t  a;
        data_t  b;
        // ALU entries with shift amounts above 31
        add_entry(OP_ADD,  32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000);
        add_entry(OP_SUB,  32'h0000_0005, 32'h0000_0007, 32'hffff_fffe);
        add_entry(OP_AND,  32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'h00f0_00f0);
        add_entry(OP_OR,   32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'hfff0_fff0);
        add_entry(OP_XOR,  32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'hff00_ff00);
        add_entry(OP_SLL,  32'h0000_0001, 32'h0000_0024, 32'h0000_0010);
        add_entry(OP_SRL,  32'h8000_0000, 32'h0000_003f, 32'h0000_0001);
        add_entry(OP_SRA,  32'h8000_0000, 32'h0000_0021, 32'hc000_0000);
        add_entry(OP_SLT,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0001);
        add_entry(OP_SLTU, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000);
        add_entry(OP_SLT,  32'h0000_0001, 32'hffff_ffff, 32'h0000_0000);
        add_entry(OP_SLTU, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0001);
        add_entry(OP_MUL,  32'h0001_0001, 32'h0001_0001, 32'h0002_0001);
        add_entry(OP_MUL,  32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001);
        // Divider entries
        add_entry(OP_DIV,  32'hffff_fff9, 32'h0000_0002, 32'hffff_fffd);
        add_entry(OP_MOD,  32'hffff_fff9, 32'h0000_0002, 32'hffff_ffff);
        add_entry(OP_DIV,  32'h0000_0007, 32'hffff_fffe, 32'hffff_fffd);
        add_entry(OP_MOD,  32'h0000_0007, 32'hffff_fffe, 32'h0000_0001);
        add_entry(OP_DIVU, 32'hffff_fff9, 32'h0000_0002, 32'h7fff_fffc);
        add_entry(OP_MODU, 32'hffff_fff9, 32'h0000_0002, 32'h0000_0001);
        add_entry(OP_DIV,  32'h0000_0064, 32'h0000_0000, 32'hffff_ffff);
        add_entry(OP_MOD,  32'h0000_0064, 32'h0000_0000, 32'h0000_0064);
        add_entry(OP_DIVU, 32'h8000_0000, 32'h0000_0000, 32'hffff_ffff);
        add_entry(OP_MODU, 32'h8000_0000, 32'h0000_0000, 32'h8000_0000);
        add_entry(OP_DIV,  32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
        add_entry(OP_MOD,  32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
        add_entry(OP_DIVU, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
        add_entry(OP_MODU, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
        // Random mixed stream with small divisors now and then
        for (int i = 0; i < 2 * N_RAND; i++) begin
            op = ex_op_e'($urandom_range(14));
            a  = $urandom;
            b  = ($urandom_range(3) == 0) ? data_t'($urandom_range(9)) : data_t'($urandom);
            add_entry(op, a, b, expected_result(op, a, b));
        end
    endtask

    // Send entries back to back while upstream credits last
    task automatic send_range(input int first, input int last);
        int idx;
        int wait_cycles;
        idx = first;
        wait_cycles = 0;
        while (idx < last && !timed_out) begin
            @(posedge clk);
            if (up_sent < IQ_DEPTH + up_returned) begin
                in_valid_i <= 1'b1;
                in_op_i    <= tbl_op[idx];
                in_a_i     <= tbl_a[idx];
                in_b_i     <= tbl_b[idx];
                in_tag_i   <= tag_t'(idx % 16);
                up_sent++;
                idx++;
                wait_cycles = 0;
            end else begin
                in_valid_i <= 1'b0;
                wait_cycles++;
                if (wait_cycles > TIMEOUT) begin
                    timed_out = 1'b1;
                    $display("Timeout: no upstream credit came back at %0t", $time);
                end
            end
        end
        @(posedge clk);
        in_valid_i <= 1'b0;
    endtask

    task automatic wait_drain();
        int wait_cycles;
        wait_cycles = 0;
        while (!timed_out && dn_received < up_sent) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > TIMEOUT) begin
                timed_out = 1'b1;
                $display("Timeout: %0d of %0d results arrived by %0t",
                         dn_received, up_sent, $time);
            end
        end
    endtask

    task automatic check_result();
        data_t  exp_data;
        tag_t   exp_tag;
        ex_op_e exp_op;
        n_checks++;
        assert (exp_idx < up_sent) else begin
            errors++;
            $display("ERR %0t: extra result with tag %0d", $time, out_tag_o);
        end
        if (exp_idx < up_sent) begin
            exp_data = tbl_exp[exp_idx];
            exp_tag  = tag_t'(exp_idx % 16);
            exp_op   = tbl_op[exp_idx];
            n_checks++;
            assert (out_tag_o == exp_tag && out_data_o == exp_data) else begin
                errors++;
                $display("ERR %0t: item %0d %s got tag %0d data %h, expected tag %0d data %h",
                         $time, exp_idx, exp_op.name(), out_tag_o, out_data_o,
                         exp_tag, exp_data);
            end
        end
        dn_received++;
        exp_idx++;
        n_checks++;
        assert (dn_received <= OUT_CREDITS + dn_returned) else begin
            errors++;
            $display("ERR %0t: %0d results sent on %0d downstream credits",
                     $time, dn_received, OUT_CREDITS + dn_returned);
        end
    endtask

    // Output monitor sampling on the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (in_credit_o) begin
                    up_returned++;
                    n_checks++;
                    assert (up_returned <= up_sent) else begin
                        errors++;
                        $display("ERR %0t: upstream credit with nothing sent", $time);
                    end
                end
                if (out_valid_o) begin
                    check_result();
                end
            end
        end
    end

    // Downstream returns one credit per result and holds them back in hold mode
    initial begin
        out_credit_i = 1'b0;
        forever begin
            @(posedge clk);
            cyc++;
            if (!rst && dn_received > dn_returned && (!hold_mode || cyc % 24 >= 20)) begin
                out_credit_i <= 1'b1;
                dn_returned++;
            end else begin
                out_credit_i <= 1'b0;
            end
        end
    end

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before || timed_out) begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - err_before);
        end else begin
            $display("Test %s: ok", name);
        end
    endtask

    task automatic run_test(input string name, input int first, input int last,
                            input logic hold);
        int err_before;
        err_before = errors;
        @(negedge clk);
        hold_mode = hold;
        send_range(first, last);
        wait_drain();
        report_test(name, err_before);
    endtask

    initial begin
        int err_before;
        in_valid_i = 1'b0;
        in_op_i    = OP_ADD;
        in_a_i     = '0;
        in_b_i     = '0;
        in_tag_i   = '0;
        rst        = 1'b1;
        void'($urandom(SEED));
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        err_before = errors;
        repeat (6) begin
            @(negedge clk);
            n_checks++;
            assert (!out_valid_o && !in_credit_o) else begin
                errors++;
                $display("ERR %0t: output active right after reset", $time);
            end
        end
        report_test("reset state", err_before);

        run_test("alu operations", 0, N_ALU, 1'b0);
        run_test("divider", N_ALU, N_ALU + N_DIV, 1'b0);
        run_test("ordering", N_ALU + N_DIV, N_ALU + N_DIV + N_RAND, 1'b0);
        run_test("downstream back-pressure", N_ALU + N_DIV + N_RAND,
                 N_ALU + N_DIV + 2 * N_RAND, 1'b1);

        // Every pop has returned its credit once all results drained
        err_before = errors;
        n_checks++;
        assert (up_returned == up_sent && exp_idx == up_sent) else begin
            errors++;
            $display("ERR %0t: %0d credits and %0d results for %0d instructions",
                     $time, up_returned, exp_idx, up_sent);
        end
        report_test("upstream credits", err_before);

        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, n_checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu
    import ex_pkg::*;
(
    input  wire ex_op_e op_i,
    input  wire data_t  a_i,
    input  wire data_t  b_i,
    output data_t       result_o
);

    shamt_t shamt;
    logic   lt_signed;
    logic   lt_unsigned;

    // Only the low five bits of b count for shifts
    assign shamt = b_i[4:0];

    assign lt_signed   = ($signed(a_i) < $signed(b_i));
    assign lt_unsigned = (a_i < b_i);

    always_comb begin
        case (op_i)
            OP_ADD: begin
                result_o = a_i + b_i;
            end
            OP_SUB: begin
                result_o = a_i - b_i;
            end
            OP_AND: begin
                result_o = a_i & b_i;
            end
            OP_OR: begin
                result_o = a_i | b_i;
            end
            OP_XOR: begin
                result_o = a_i ^ b_i;
            end
            OP_SLL: begin
                result_o = a_i << shamt;
            end
            OP_SRL: begin
                result_o = a_i >> shamt;
            end
            OP_SRA: begin
                result_o = data_t'($signed(a_i) >>> shamt);
            end
            OP_SLT: begin
                result_o = {31'b0, lt_signed};
            end
            OP_SLTU: begin
                result_o = {31'b0, lt_unsigned};
            end
            OP_MUL: begin
                // Low word of the product only
                result_o = a_i * b_i;
            end
            OP_DIV, OP_DIVU, OP_MOD, OP_MODU: begin
                // Handled by the divider
                result_o = '0;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/ex_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_divider
    import ex_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   start_i,
    input  wire ex_op_e op_i,
    input  wire data_t  a_i,
    input  wire data_t  b_i,
    output logic        busy_o,
    output logic        done_o,
    output data_t       result_o
);

    div_state_e state_q;
    logic [4:0] step_q;

    // Working registers
    data_t quo_q;
    data_t rem_q;
    data_t dvsr_q;
    logic  q_neg_q;
    logic  r_neg_q;
    logic  rem_sel_q;
    logic  b_zero_q;

    logic        is_signed;
    logic        a_neg;
    logic        b_neg;
    logic [32:0] rem_shift;
    logic [33:0] diff;
    data_t       q_fix;
    data_t       r_fix;

    assign is_signed = (op_i == OP_DIV) || (op_i == OP_MOD);
    assign a_neg     = is_signed && a_i[31];
    assign b_neg     = is_signed && b_i[31];

    // One restoring step, widened so the subtraction cannot wrap
    assign rem_shift = {rem_q, quo_q[31]};
    assign diff      = {1'b0, rem_shift} - {2'b0, dvsr_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= DIV_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= DIV_RUN;
                        step_q  <= '0;
                    end
                end
                DIV_RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == 5'd31) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: begin
                    state_q <= DIV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && start_i) begin
            quo_q     <= a_neg ? -a_i : a_i;
            dvsr_q    <= b_neg ? -b_i : b_i;
            rem_q     <= '0;
            q_neg_q   <= a_neg ^ b_neg;
            r_neg_q   <= a_neg;
            rem_sel_q <= (op_i == OP_MOD) || (op_i == OP_MODU);
            b_zero_q  <= (b_i == '0);
        end else if (state_q == DIV_RUN) begin
            if (!diff[33]) begin
                rem_q <= diff[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= rem_shift[31:0];
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    // Sign fix-up; min / -1 falls out as quotient a, remainder 0
    always_comb begin
        q_fix = q_neg_q ? -quo_q : quo_q;
        if (b_zero_q) begin
            q_fix = '1;
        end
        // Remainder takes the sign of a, also gives a back on divide by zero
        r_fix = r_neg_q ? -rem_q : rem_q;
    end

    assign result_o = rem_sel_q ? r_fix : q_fix;
    assign busy_o   = (state_q != DIV_IDLE);
    assign done_o   = (state_q == DIV_DONE);

endmodule

`default_nettype wire

/* logic/ex_issue_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_issue_buffer
    import ex_pkg::*;
#(
    parameter int IQ_DEPTH = 4
) (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   in_valid_i,
    input  wire ex_op_e in_op_i,
    input  wire data_t  in_a_i,
    input  wire data_t  in_b_i,
    input  wire tag_t   in_tag_i,
    output logic        in_credit_o,
    input  wire logic   iq_pop_i,
    output logic        iq_valid_o,
    output ex_op_e      iq_op_o,
    output data_t       iq_a_o,
    output data_t       iq_b_o,
    output tag_t        iq_tag_o
);

    localparam int PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(IQ_DEPTH + 1);

    // Entry storage
    ex_op_e op_mem  [IQ_DEPTH];
    data_t  a_mem   [IQ_DEPTH];
    data_t  b_mem   [IQ_DEPTH];
    tag_t   tag_mem [IQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            op_mem[wr_ptr_q]  <= in_op_i;
            a_mem[wr_ptr_q]   <= in_a_i;
            b_mem[wr_ptr_q]   <= in_b_i;
            tag_mem[wr_ptr_q] <= in_tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            in_credit_o <= 1'b0;
        end else begin
            // Upstream only sends on a credit, so space is guaranteed
            if (in_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(IQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (iq_pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(IQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({in_valid_i, iq_pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // One credit back per freed entry
            in_credit_o <= iq_pop_i;
        end
    end

    assign iq_valid_o = (count_q != '0);
    assign iq_op_o    = op_mem[rd_ptr_q];
    assign iq_a_o     = a_mem[rd_ptr_q];
    assign iq_b_o     = b_mem[rd_ptr_q];
    assign iq_tag_o   = tag_mem[rd_ptr_q];

endmodule

`default_nettype wire

/* logic/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    // Operand and result word
    typedef logic [31:0] data_t;

    // Shift amount from the low bits of operand b
    typedef logic [4:0] shamt_t;

    // Instruction tag, carried unchanged to the output
    typedef logic [3:0] tag_t;

    // Operations handled by the execute unit
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9,
        OP_MUL  = 4'd10,
        OP_DIV  = 4'd11,
        OP_DIVU = 4'd12,
        OP_MOD  = 4'd13,
        OP_MODU = 4'd14
    } ex_op_e;

    // Iterative divider FSM
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_e;

endpackage

`default_nettype wire

/* logic/ex_result_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_result_buffer
    import ex_pkg::*;
#(
    parameter int RB_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  push_i,
    input  wire data_t data_i,
    input  wire tag_t  tag_i,
    output logic       room_o,
    output logic       out_valid_o,
    output data_t      out_data_o,
    output tag_t       out_tag_o,
    input  wire logic  out_credit_i
);

    localparam int PTR_W = (RB_DEPTH > 1) ? $clog2(RB_DEPTH) : 1;
    localparam int CNT_W = $clog2(RB_DEPTH + 1);
    localparam int CR_W  = $clog2(OUT_CREDITS + 1);

    data_t data_mem [RB_DEPTH];
    tag_t  tag_mem  [RB_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CR_W-1:0]  credit_q;
    logic             send;

    // Send the head whenever a downstream credit is held
    assign send = (count_q != '0) && (credit_q != '0);

    // Two free entries, one of them for a push already in flight
    assign room_o = (int'(count_q) + 2 <= RB_DEPTH);

    always_ff @(posedge clk) begin
        if (push_i) begin
            data_mem[wr_ptr_q] <= data_i;
            tag_mem[wr_ptr_q]  <= tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            credit_q    <= CR_W'(OUT_CREDITS);
            out_valid_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(RB_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (send) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(RB_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, send})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // Returned credit and a send may land together
            credit_q    <= credit_q + CR_W'(out_credit_i) - CR_W'(send);
            out_valid_o <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_data_o <= data_mem[rd_ptr_q];
            out_tag_o  <= tag_mem[rd_ptr_q];
        end
    end

endmodule

`default_nettype wire

/* logic/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import ex_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   iq_valid_i,
    input  wire ex_op_e iq_op_i,
    input  wire data_t  iq_a_i,
    input  wire data_t  iq_b_i,
    input  wire tag_t   iq_tag_i,
    output logic        iq_pop_o,
    input  wire logic   rb_room_i,
    output logic        rb_push_o,
    output data_t       rb_data_o,
    output tag_t        rb_tag_o
);

    logic  is_div;
    logic  alu_pop;
    logic  div_start;
    logic  div_busy;
    logic  div_done;
    data_t alu_result;
    data_t div_result;
    tag_t  div_tag_q;

    assign is_div = (iq_op_i == OP_DIV) || (iq_op_i == OP_DIVU) ||
                    (iq_op_i == OP_MOD) || (iq_op_i == OP_MODU);

    // Issue stalls while a divide is in flight, which keeps results in order
    assign iq_pop_o  = iq_valid_i && rb_room_i && !div_busy;
    assign alu_pop   = iq_pop_o && !is_div;
    assign div_start = iq_pop_o && is_div;

    ex_alu ex_alu_inst (
        .op_i     (iq_op_i),
        .a_i      (iq_a_i),
        .b_i      (iq_b_i),
        .result_o (alu_result)
    );

    ex_divider ex_divider_inst (
        .clk      (clk),
        .rst      (rst),
        .start_i  (div_start),
        .op_i     (iq_op_i),
        .a_i      (iq_a_i),
        .b_i      (iq_b_i),
        .busy_o   (div_busy),
        .done_o   (div_done),
        .result_o (div_result)
    );

    // Park the divide tag until its result comes back
    always_ff @(posedge clk) begin
        if (div_start) begin
            div_tag_q <= iq_tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rb_push_o <= 1'b0;
        end else begin
            rb_push_o <= alu_pop || div_done;
        end
    end

    // ALU pop and divider done never share a cycle
    always_ff @(posedge clk) begin
        if (alu_pop) begin
            rb_data_o <= alu_result;
            rb_tag_o  <= iq_tag_i;
        end else if (div_done) begin
            rb_data_o <= div_result;
            rb_tag_o  <= div_tag_q;
        end
    end

endmodule

`default_nettype wire

/* logic/ex_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_unit_top
    import ex_pkg::*;
#(
    parameter int IQ_DEPTH    = 4,
    parameter int RB_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   in_valid_i,
    input  wire ex_op_e in_op_i,
    input  wire data_t  in_a_i,
    input  wire data_t  in_b_i,
    input  wire tag_t   in_tag_i,
    output logic        in_credit_o,
    output logic        out_valid_o,
    output data_t       out_data_o,
    output tag_t        out_tag_o,
    input  wire logic   out_credit_i
);

    // Issue buffer head
    logic   iq_valid;
    logic   iq_pop;
    ex_op_e iq_op;
    data_t  iq_a;
    data_t  iq_b;
    tag_t   iq_tag;

    // Toward the result buffer
    logic  rb_room;
    logic  rb_push;
    data_t rb_data;
    tag_t  rb_tag;

    ex_issue_buffer #(
        .IQ_DEPTH (IQ_DEPTH)
    ) ex_issue_buffer_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .in_op_i     (in_op_i),
        .in_a_i      (in_a_i),
        .in_b_i      (in_b_i),
        .in_tag_i    (in_tag_i),
        .in_credit_o (in_credit_o),
        .iq_pop_i    (iq_pop),
        .iq_valid_o  (iq_valid),
        .iq_op_o     (iq_op),
        .iq_a_o      (iq_a),
        .iq_b_o      (iq_b),
        .iq_tag_o    (iq_tag)
    );

    ex_stage ex_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .iq_valid_i (iq_valid),
        .iq_op_i    (iq_op),
        .iq_a_i     (iq_a),
        .iq_b_i     (iq_b),
        .iq_tag_i   (iq_tag),
        .iq_pop_o   (iq_pop),
        .rb_room_i  (rb_room),
        .rb_push_o  (rb_push),
        .rb_data_o  (rb_data),
        .rb_tag_o   (rb_tag)
    );

    ex_result_buffer #(
        .RB_DEPTH    (RB_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) ex_result_buffer_inst (
        .clk          (clk),
        .rst          (rst),
        .push_i       (rb_push),
        .data_i       (rb_data),
        .tag_i        (rb_tag),
        .room_o       (rb_room),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_tag_o    (out_tag_o),
        .out_credit_i (out_credit_i)
    );

endmodule

`default_nettype wire

/* project.f */
+incdir+bench
logic/ex_pkg.sv
logic/ex_issue_buffer.sv
logic/ex_alu.sv
logic/ex_divider.sv
logic/ex_stage.sv
logic/ex_result_buffer.sv
logic/ex_unit_top.sv
bench/ex_unit_tb.sv
